//--- src.f
hw/uart_pkg.sv
hw/uart_regs.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/uart_core.sv
hw/uart_top.sv
sim/uart_properties.sv
sim/tb_uart.sv

//--- Makefile
TOP = tb_uart

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f src.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "test passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- sim/tb_uart.sv
`timescale 1ns/1ps

module tb_uart import uart_pkg::*; ();

   localparam div_t DIV_RST     = div_t'(16);
   localparam int   CYCLE_LIMIT = 60 * 10 * 16 + 2000; // 60 frames at the widest bit, plus slack
   localparam int   POLL_LIMIT  = 400;

   logic      clk_i;
   logic      arst_i;
   bus_req_s  bus_req;
   bus_data_t bus_rdata;
   logic      rxd;
   logic      txd;
   logic      cts;
   logic      rts;

   integer seed       = 32'h86a3_0e86;
   int     mismatches = 0;
   int     timeouts   = 0;
   int     cycle_cnt  = 0;
   div_t   cur_div;

   uart_top #(
      .DIV_RST (DIV_RST)
   ) i_dut (
      .clk_i       (clk_i),
      .arst_i      (arst_i),
      .bus_req_i   (bus_req),
      .bus_rdata_o (bus_rdata),
      .rxd_i       (rxd),
      .txd_o       (txd),
      .cts_i       (cts),
      .rts_o       (rts)
   );

   initial begin
      clk_i = 1'b0;
      forever #20 clk_i = ~clk_i;
   end

   always @(posedge clk_i) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt == CYCLE_LIMIT) begin
         $display("run did not finish within %0d cycles", CYCLE_LIMIT);
         $display("test failed");
         $finish;
      end
   end

   //////////////////////////////////////////////////
   // compare tasks
   //////////////////////////////////////////////////

   task automatic check_byte(input byte_t actual, input byte_t expected, input string what);
      if (actual !== expected) begin
         $display("FAIL %0t: %s is %h, expected %h", $time, what, actual, expected);
         mismatches++;
      end
   endtask

   task automatic check_data(input bus_data_t actual, input bus_data_t expected,
                             input string what);
      if (actual !== expected) begin
         $display("FAIL %0t: %s is %h, expected %h", $time, what, actual, expected);
         mismatches++;
      end
   endtask

   task automatic check_bit(input logic actual, input logic expected, input string what);
      if (actual !== expected) begin
         $display("FAIL %0t: %s is %b, expected %b", $time, what, actual, expected);
         mismatches++;
      end
   endtask

   //////////////////////////////////////////////////
   // bus and line helpers
   //////////////////////////////////////////////////

   // every helper starts and ends 1 ns after a rising edge
   task automatic idle_cycles(input int n);
      repeat (n) @(posedge clk_i);
      #1;
   endtask

   task automatic bus_write(input reg_addr_t addr, input bus_data_t data);
      bus_req = {1'b1, 1'b1, addr, data};
      @(posedge clk_i);
      #1;
      bus_req = '0;
   endtask

   task automatic bus_read(input reg_addr_t addr, output bus_data_t data);
      bus_req = {1'b1, 1'b0, addr, 16'h0000};
      #5; // combinational read has settled
      data = bus_rdata;
      @(posedge clk_i);
      #1;
      bus_req = '0;
   endtask

   task automatic wait_flag(input reg_addr_t addr, input logic value, input string what);
      bus_data_t data;
      int        n;
      n = 0;
      bus_read(addr, data);
      while (data[0] !== value && n < POLL_LIMIT) begin
         bus_read(addr, data);
         n++;
      end
      if (data[0] !== value) begin
         $display("timeout waiting for %s", what);
         timeouts++;
      end
   endtask

   task automatic drive_bit(input logic b, input div_t div);
      rxd = b;
      repeat (int'(div)) @(posedge clk_i);
      #1;
   endtask

   task automatic send_frame(input byte_t data, input div_t div);
      drive_bit(1'b0, div); // start
      for (int i = 0; i < 8; i++) begin
         drive_bit(data[i], div);
      end
      drive_bit(1'b1, div); // stop
   endtask

   // samples txd at mid-bit on falling edges from the start edge on
   task automatic capture_frame(input div_t div, output byte_t data);
      logic [9:0] bits;
      int         n;
      n    = 0;
      bits = '0;
      @(negedge clk_i);
      while (txd !== 1'b0 && n < 20 * int'(div)) begin
         @(negedge clk_i);
         n++;
      end
      if (txd !== 1'b0) begin
         $display("timeout waiting for a start bit on txd");
         timeouts++;
      end else begin
         repeat (int'(div) / 2) @(negedge clk_i);
         for (int i = 0; i < 10; i++) begin
            bits[i] = txd;
            if (i < 9) repeat (int'(div)) @(negedge clk_i);
         end
         check_bit(bits[0], 1'b0, "start bit on txd");
         check_bit(bits[9], 1'b1, "stop bit on txd");
      end
      data = bits[8:1];
      @(posedge clk_i);
      #1;
   endtask

   task automatic watch_txd_high(input int cycles, input string what);
      logic high;
      high = 1'b1;
      repeat (cycles) begin
         @(negedge clk_i);
         high = high & txd;
      end
      check_bit(high, 1'b1, what);
      @(posedge clk_i);
      #1;
   endtask

   //////////////////////////////////////////////////
   // directed tests
   //////////////////////////////////////////////////

   task automatic test_reset_values();
      bus_data_t data;
      bus_read(ADDR_DIV, data);
      check_data(data, 16'd16, "DIV after reset");
      bus_read(ADDR_TXEN, data);
      check_data(data, 16'd0, "TXEN after reset");
      bus_read(ADDR_RXEN, data);
      check_data(data, 16'd0, "RXEN after reset");
      bus_read(ADDR_TXREADY, data);
      check_data(data, 16'd0, "TXREADY after reset");
      bus_read(ADDR_RXREADY, data);
      check_data(data, 16'd0, "RXREADY after reset");
      check_bit(txd, 1'b1, "txd after reset");
      check_bit(rts, 1'b0, "rts after reset");
      bus_write(ADDR_DIV, 16'd8);
      cur_div = div_t'(8);
      bus_read(ADDR_DIV, data);
      check_data(data, 16'd8, "DIV readback");
   endtask

   task automatic test_transmit();
      byte_t payload;
      byte_t got;
      bus_write(ADDR_TXEN, 16'd1);
      wait_flag(ADDR_TXREADY, 1'b1, "TXREADY after enable");
      for (int i = 0; i < 4; i++) begin
         payload = byte_t'($random(seed));
         bus_write(ADDR_TXDATA, bus_data_t'(payload));
         capture_frame(cur_div, got);
         check_byte(got, payload, "byte on txd");
         wait_flag(ADDR_TXREADY, 1'b1, "TXREADY after frame");
      end
   endtask

   task automatic test_receive(input div_t div);
      byte_t     payload;
      bus_data_t data;
      bus_write(ADDR_DIV, bus_data_t'(div));
      cur_div = div;
      bus_write(ADDR_RXEN, 16'd1);
      idle_cycles(2);
      check_bit(rts, 1'b1, "rts with RXEN set");
      idle_cycles(2 * int'(div) + 4); // idle line for the receiver to sync on
      for (int i = 0; i < 2; i++) begin
         payload = byte_t'($random(seed));
         send_frame(payload, div);
         wait_flag(ADDR_RXREADY, 1'b1, "RXREADY after frame");
         bus_read(ADDR_RXDATA, data);
         check_data(data, bus_data_t'(payload), "RXDATA");
         bus_read(ADDR_RXREADY, data);
         check_data(data, 16'd0, "RXREADY after RXDATA read");
      end
   endtask

   task automatic test_flow_control();
      byte_t     payload;
      byte_t     got;
      bus_data_t data;
      cts = 1'b0;
      idle_cycles(4); // through the cts synchronizer
      payload = byte_t'($random(seed));
      bus_write(ADDR_TXDATA, bus_data_t'(payload));
      watch_txd_high(3 * int'(cur_div), "txd with cts low");
      bus_read(ADDR_TXREADY, data);
      check_data(data, 16'd0, "TXREADY with cts low");
      cts = 1'b1;
      wait_flag(ADDR_TXREADY, 1'b1, "TXREADY after cts rise");
      payload = byte_t'($random(seed));
      bus_write(ADDR_TXDATA, bus_data_t'(payload));
      capture_frame(cur_div, got);
      check_byte(got, payload, "byte on txd after cts rise");
      wait_flag(ADDR_TXREADY, 1'b1, "TXREADY after frame");
   endtask

   task automatic test_false_start();
      byte_t     payload;
      bus_data_t data;
      rxd = 1'b0;
      idle_cycles(int'(cur_div) / 4); // glitch well under half a bit
      rxd = 1'b1;
      idle_cycles(12 * int'(cur_div)); // long enough for a bogus frame to finish
      bus_read(ADDR_RXREADY, data);
      check_data(data, 16'd0, "RXREADY after glitch");
      payload = byte_t'($random(seed));
      send_frame(payload, cur_div);
      wait_flag(ADDR_RXREADY, 1'b1, "RXREADY after glitch and frame");
      bus_read(ADDR_RXDATA, data);
      check_data(data, bus_data_t'(payload), "RXDATA after glitch");
   endtask

   task automatic test_soft_reset();
      bus_data_t data;
      bus_write(ADDR_TXDATA, 16'h0000); // zero byte holds txd low through the data bits
      idle_cycles(2 * int'(cur_div) + 4);
      check_bit(txd, 1'b0, "txd mid-frame");
      bus_write(ADDR_SOFTRESET, 16'd1);
      check_bit(txd, 1'b1, "txd right after soft reset");
      watch_txd_high(10 * int'(cur_div), "txd after soft reset");
      wait_flag(ADDR_TXREADY, 1'b1, "TXREADY after soft reset");
      bus_read(ADDR_DIV, data);
      check_data(data, bus_data_t'(cur_div), "DIV after soft reset");
   endtask

   initial begin
      arst_i  = 1'b0;
      bus_req = '0;
      rxd     = 1'b1;
      cts     = 1'b1;
      cur_div = DIV_RST;
      repeat (3) @(posedge clk_i);
      #1;
      arst_i = 1'b1;
      test_reset_values();
      test_transmit();
      test_receive(div_t'(16));
      test_receive(div_t'(8));
      test_flow_control();
      test_false_start();
      test_soft_reset();
      $display("errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
      if (mismatches + timeouts == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

//--- sim/uart_properties.sv
`timescale 1ns/1ps

module uart_properties (
   input logic clk_i,
   input logic arst_i,
   input logic soft_rst_i,
   input logic data_write_en_i,
   input logic txd_i,
   input logic rts_i,
   input logic tx_ready_i,
   input logic rx_ready_i
);

   // line idles while the transmitter offers to take a byte
   ready_idle_a: assert property (@(posedge clk_i) disable iff (!arst_i)
      tx_ready_i |-> txd_i)
      else $error("txd low while tx_ready is high");

   soft_rst_a: assert property (@(posedge clk_i) disable iff (!arst_i)
      soft_rst_i |=> (!rts_i && !tx_ready_i && !rx_ready_i))
      else $error("rts or a ready flag high after soft reset");

   write_clears_ready_a: assert property (@(posedge clk_i) disable iff (!arst_i)
      data_write_en_i |=> !tx_ready_i)
      else $error("tx_ready still high after a data write");

endmodule

bind uart_core uart_properties i_props (
   .clk_i           (clk_i),
   .arst_i          (arst_i),
   .soft_rst_i      (soft_rst_i),
   .data_write_en_i (data_write_en_i),
   .txd_i           (txd_o),
   .rts_i           (rts_o),
   .tx_ready_i      (tx_ready_o),
   .rx_ready_i      (rx_ready_o)
);

//--- hw/uart_top.sv
`timescale 1ns/1ps

module uart_top import uart_pkg::*; #(
   parameter div_t DIV_RST = div_t'(16)
) (
   input  logic      clk_i,
   input  logic      arst_i,
   input  bus_req_s  bus_req_i,
   output bus_data_t bus_rdata_o,
   input  logic      rxd_i,
   output logic      txd_o,
   input  logic      cts_i,
   output logic      rts_o
);

   div_t  div;
   logic  tx_en;
   logic  rx_en;
   byte_t tx_data;
   byte_t rx_data;
   logic  soft_rst;
   logic  data_write_en;
   logic  data_read_en;
   logic  tx_ready;
   logic  rx_ready;

   uart_regs #(
      .DIV_RST (DIV_RST)
   ) i_regs (
      .clk_i           (clk_i),
      .arst_i          (arst_i),
      .bus_req_i       (bus_req_i),
      .bus_rdata_o     (bus_rdata_o),
      .tx_ready_i      (tx_ready),
      .rx_ready_i      (rx_ready),
      .rx_data_i       (rx_data),
      .div_o           (div),
      .tx_en_o         (tx_en),
      .rx_en_o         (rx_en),
      .tx_data_o       (tx_data),
      .soft_rst_o      (soft_rst),
      .data_write_en_o (data_write_en),
      .data_read_en_o  (data_read_en)
   );

   uart_core i_core (
      .clk_i           (clk_i),
      .arst_i          (arst_i),
      .soft_rst_i      (soft_rst),
      .tx_en_i         (tx_en),
      .rx_en_i         (rx_en),
      .tx_data_i       (tx_data),
      .data_write_en_i (data_write_en),
      .data_read_en_i  (data_read_en),
      .div_i           (div),
      .rxd_i           (rxd_i),
      .cts_i           (cts_i),
      .txd_o           (txd_o),
      .rts_o           (rts_o),
      .tx_ready_o      (tx_ready),
      .rx_ready_o      (rx_ready),
      .rx_data_o       (rx_data)
   );

endmodule

//--- hw/uart_core.sv
`timescale 1ns/1ps

module uart_core import uart_pkg::*; (
   input  logic  clk_i,
   input  logic  arst_i,
   input  logic  soft_rst_i,
   input  logic  tx_en_i,
   input  logic  rx_en_i,
   input  byte_t tx_data_i,
   input  logic  data_write_en_i,
   input  logic  data_read_en_i,
   input  div_t  div_i,
   input  logic  rxd_i,
   input  logic  cts_i,
   output logic  txd_o,
   output logic  rts_o,
   output logic  tx_ready_o,
   output logic  rx_ready_o,
   output byte_t rx_data_o
);

   logic [1:0] cts_ff_q;
   logic       cts_sync;

   // two-stage synchronizer for the async cts input
   always_ff @(posedge clk_i or negedge arst_i) begin
      if (!arst_i) cts_ff_q <= '0;
      else         cts_ff_q <= {cts_ff_q[0], cts_i};
   end

   assign cts_sync = cts_ff_q[1];

   uart_tx i_tx (
      .clk_i           (clk_i),
      .arst_i          (arst_i),
      .soft_rst_i      (soft_rst_i),
      .tx_en_i         (tx_en_i),
      .cts_i           (cts_sync),
      .data_write_en_i (data_write_en_i),
      .tx_data_i       (tx_data_i),
      .div_i           (div_i),
      .txd_o           (txd_o),
      .tx_ready_o      (tx_ready_o)
   );

   uart_rx i_rx (
      .clk_i          (clk_i),
      .arst_i         (arst_i),
      .soft_rst_i     (soft_rst_i),
      .rx_en_i        (rx_en_i),
      .rxd_i          (rxd_i),
      .data_read_en_i (data_read_en_i),
      .div_i          (div_i),
      .rx_data_o      (rx_data_o),
      .rx_ready_o     (rx_ready_o),
      .rts_o          (rts_o)
   );

endmodule

//--- hw/uart_rx.sv
`timescale 1ns/1ps

module uart_rx import uart_pkg::*; (
   input  logic  clk_i,
   input  logic  arst_i,
   input  logic  soft_rst_i,
   input  logic  rx_en_i,
   input  logic  rxd_i,
   input  logic  data_read_en_i,
   input  div_t  div_i,
   output byte_t rx_data_o,
   output logic  rx_ready_o,
   output logic  rts_o
);

   rx_state_e  state_q;
   div_t       cyc_cnt_q;
   logic [3:0] bit_cnt_q;
   byte_t      shift_q;
   logic       sample;

   // mid-bit sample point while receiving
   assign sample = rx_en_i && !soft_rst_i && (state_q == RX_DATA) &&
                   (cyc_cnt_q == div_i);

   //////////////////////////////////////////////////
   // control
   //////////////////////////////////////////////////

   always_ff @(posedge clk_i or negedge arst_i) begin
      if (!arst_i) begin
         state_q    <= RX_SYNC;
         cyc_cnt_q  <= div_t'(1);
         bit_cnt_q  <= '0;
         rx_ready_o <= 1'b0;
         rts_o      <= 1'b0;
      end else if (soft_rst_i) begin
         state_q    <= RX_SYNC;
         cyc_cnt_q  <= div_t'(1);
         bit_cnt_q  <= '0;
         rx_ready_o <= 1'b0;
         rts_o      <= 1'b0;
      end else if (rx_en_i) begin
         rts_o <= 1'b1; // stays up until a reset
         if (data_read_en_i) rx_ready_o <= 1'b0;
         case (state_q)
            RX_SYNC: begin
               cyc_cnt_q <= div_t'(1);
               bit_cnt_q <= '0;
               if (rxd_i) state_q <= RX_IDLE_CHECK;
            end
            RX_IDLE_CHECK: begin
               cyc_cnt_q <= cyc_cnt_q + 1'b1;
               if (!rxd_i) state_q <= RX_SYNC; // line dropped early
               else if (cyc_cnt_q == div_i) state_q <= RX_WAIT_START;
            end
            RX_WAIT_START: begin
               cyc_cnt_q <= div_t'(1);
               if (!rxd_i) state_q <= RX_START;
            end
            RX_START: begin
               cyc_cnt_q <= cyc_cnt_q + 1'b1;
               if (cyc_cnt_q == (div_i >> 1)) begin
                  if (rxd_i) begin
                     state_q <= RX_SYNC; // false start
                  end else begin
                     cyc_cnt_q <= div_t'(1);
                     state_q   <= RX_DATA;
                  end
               end
            end
            RX_DATA: begin
               cyc_cnt_q <= cyc_cnt_q + 1'b1;
               if (sample) begin
                  cyc_cnt_q <= div_t'(1);
                  bit_cnt_q <= bit_cnt_q + 1'b1;
                  if (bit_cnt_q == 4'd8) begin // stop bit
                     rx_ready_o <= 1'b1; // overwrites an unread byte
                     bit_cnt_q  <= '0;
                     state_q    <= RX_WAIT_START;
                  end
               end
            end
            default: state_q <= RX_SYNC;
         endcase
      end else begin
         state_q    <= RX_SYNC;
         cyc_cnt_q  <= div_t'(1);
         bit_cnt_q  <= '0;
         rx_ready_o <= 1'b0;
      end
   end

   //////////////////////////////////////////////////
   // data path
   //////////////////////////////////////////////////

   always_ff @(posedge clk_i) begin
      if (sample) begin
         if (bit_cnt_q == 4'd8) rx_data_o <= shift_q;
         else shift_q <= {rxd_i, shift_q[7:1]}; // lsb arrives first
      end
   end

endmodule

//--- hw/uart_tx.sv
`timescale 1ns/1ps

module uart_tx import uart_pkg::*; (
   input  logic  clk_i,
   input  logic  arst_i,
   input  logic  soft_rst_i,
   input  logic  tx_en_i,
   input  logic  cts_i,
   input  logic  data_write_en_i,
   input  byte_t tx_data_i,
   input  div_t  div_i,
   output logic  txd_o,
   output logic  tx_ready_o
);

   tx_state_e   state_q;
   logic [9:0]  pattern_q; // {stop, data, start}
   logic [3:0]  bit_cnt_q;
   div_t        cyc_cnt_q;

   assign txd_o = pattern_q[0]; // line idles high

   always_ff @(posedge clk_i or negedge arst_i) begin
      if (!arst_i) begin
         state_q    <= TX_IDLE;
         tx_ready_o <= 1'b0;
         pattern_q  <= '1;
         bit_cnt_q  <= '0;
         cyc_cnt_q  <= div_t'(1);
      end else if (soft_rst_i || !(tx_en_i && cts_i)) begin
         // disabled or blocked by cts, abort any frame
         state_q    <= TX_IDLE;
         tx_ready_o <= 1'b0;
         pattern_q  <= '1;
         bit_cnt_q  <= '0;
         cyc_cnt_q  <= div_t'(1);
      end else begin
         case (state_q)
            TX_IDLE: begin
               tx_ready_o <= ~data_write_en_i;
               pattern_q  <= '1;
               bit_cnt_q  <= '0;
               cyc_cnt_q  <= div_t'(1);
               if (data_write_en_i) state_q <= TX_LOAD;
            end
            TX_LOAD: begin
               pattern_q <= {1'b1, tx_data_i, 1'b0}; // start bit goes out first
               state_q   <= TX_SEND;
            end
            TX_SEND: begin
               cyc_cnt_q <= cyc_cnt_q + 1'b1;
               if (cyc_cnt_q == div_i) begin
                  if (bit_cnt_q == 4'd9) begin // stop bit done
                     state_q <= TX_IDLE;
                  end else begin
                     pattern_q <= {1'b1, pattern_q[9:1]};
                     bit_cnt_q <= bit_cnt_q + 1'b1;
                     cyc_cnt_q <= div_t'(1);
                  end
               end
            end
            default: state_q <= TX_IDLE;
         endcase
      end
   end

endmodule

//--- hw/uart_regs.sv
`timescale 1ns/1ps

module uart_regs import uart_pkg::*; #(
   parameter div_t DIV_RST = div_t'(16)
) (
   input  logic      clk_i,
   input  logic      arst_i,
   input  bus_req_s  bus_req_i,
   output bus_data_t bus_rdata_o,
   input  logic      tx_ready_i,
   input  logic      rx_ready_i,
   input  byte_t     rx_data_i,
   output div_t      div_o,
   output logic      tx_en_o,
   output logic      rx_en_o,
   output byte_t     tx_data_o,
   output logic      soft_rst_o,
   output logic      data_write_en_o,
   output logic      data_read_en_o
);

   logic  wr;
   logic  rd;
   div_t  div_q;
   logic  tx_en_q;
   logic  rx_en_q;
   byte_t tx_data_q;

   assign wr = bus_req_i.valid & bus_req_i.write;
   assign rd = bus_req_i.valid & ~bus_req_i.write;

   // one-cycle strobes, straight from the request
   assign soft_rst_o      = wr && (bus_req_i.addr == ADDR_SOFTRESET);
   assign data_write_en_o = wr && (bus_req_i.addr == ADDR_TXDATA);
   assign data_read_en_o  = rd && (bus_req_i.addr == ADDR_RXDATA);

   always_ff @(posedge clk_i or negedge arst_i) begin
      if (!arst_i) begin
         div_q   <= DIV_RST;
         tx_en_q <= 1'b0;
         rx_en_q <= 1'b0;
      end else if (wr) begin
         case (bus_req_i.addr)
            ADDR_DIV:  div_q   <= bus_req_i.wdata;
            ADDR_TXEN: tx_en_q <= bus_req_i.wdata[0];
            ADDR_RXEN: rx_en_q <= bus_req_i.wdata[0];
            default: ;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (data_write_en_o) begin
         tx_data_q <= bus_req_i.wdata[7:0]; // byte to send
      end
   end

   // read mux, write-only and idle cycles return 0
   always_comb begin
      bus_rdata_o = '0;
      if (rd) begin
         case (bus_req_i.addr)
            ADDR_DIV:     bus_rdata_o = div_q;
            ADDR_TXEN:    bus_rdata_o = {15'd0, tx_en_q};
            ADDR_RXEN:    bus_rdata_o = {15'd0, rx_en_q};
            ADDR_TXREADY: bus_rdata_o = {15'd0, tx_ready_i};
            ADDR_RXREADY: bus_rdata_o = {15'd0, rx_ready_i};
            ADDR_RXDATA:  bus_rdata_o = {8'd0, rx_data_i};
            default:      bus_rdata_o = '0;
         endcase
      end
   end

   assign div_o     = div_q;
   assign tx_en_o   = tx_en_q;
   assign rx_en_o   = rx_en_q;
   assign tx_data_o = tx_data_q;

endmodule

//--- hw/uart_pkg.sv
package uart_pkg;

   //////////////////////////////////////////////////
   // widths with a meaning
   //////////////////////////////////////////////////

   typedef logic [15:0] div_t;      // bit duration in clock cycles
   typedef logic [7:0]  byte_t;     // one data byte
   typedef logic [2:0]  reg_addr_t; // register address
   typedef logic [15:0] bus_data_t; // bus data word

   //////////////////////////////////////////////////
   // register map
   //////////////////////////////////////////////////

   localparam reg_addr_t ADDR_SOFTRESET = 3'd0; // write pulse
   localparam reg_addr_t ADDR_DIV       = 3'd1;
   localparam reg_addr_t ADDR_TXEN      = 3'd2;
   localparam reg_addr_t ADDR_RXEN      = 3'd3;
   localparam reg_addr_t ADDR_TXREADY   = 3'd4; // read only
   localparam reg_addr_t ADDR_RXREADY   = 3'd5; // read only
   localparam reg_addr_t ADDR_TXDATA    = 3'd6; // write only
   localparam reg_addr_t ADDR_RXDATA    = 3'd7; // read only

   // one host request, 21 bits
   typedef struct packed {
      logic      valid;
      logic      write;
      reg_addr_t addr;
      bus_data_t wdata;
   } bus_req_s;

   //////////////////////////////////////////////////
   // state machines
   //////////////////////////////////////////////////

   typedef enum logic [1:0] {
      TX_IDLE,
      TX_LOAD,
      TX_SEND
   } tx_state_e;

   typedef enum logic [2:0] {
      RX_SYNC,
      RX_IDLE_CHECK,
      RX_WAIT_START,
      RX_START,
      RX_DATA
   } rx_state_e;

endpackage
